/* hw/timetag_pkg.sv */
package timetag_pkg;

	// Detector inputs and laser channels
	localparam int n_detectors = 4;

	// Free-running timestamp counter width
	localparam int time_width = 43;

	// Sample FIFO entries
	localparam int fifo_depth = 16;

	// Command targets: timer run, sequencer run, four laser channels
	localparam int n_targets = 6;

	// Header codes, the laser channels take tgt_seq0 upward
	localparam int tgt_timer = 0;
	localparam int tgt_seq_run = 1;
	localparam int tgt_seq0 = 2;

	// Bit positions in the data byte of a run-control command
	localparam int run_start_bit = 0;
	localparam int run_stop_bit = 1;
	localparam int run_clear_bit = 2;

	// One sample goes back to the host as this many bytes
	localparam int sample_bytes = 6;

	// Command on its way to a target
	typedef struct packed {
		logic [n_targets-1:0] sel;
		logic [7:0] data;
	} cmd_t;

	// Queued sample, most significant field first
	typedef struct packed {
		logic lost;
		logic [n_detectors-1:0] mask;
		logic [time_width-1:0] timestamp;
	} sample_t;

endpackage

/* hw/cmd_parser.sv */
module cmd_parser (
	input logic clk,
	input logic rst_n,
	input logic cmd_wr,
	input logic [7:0] cmd_in,
	output logic cmd_ready,
	output timetag_pkg::cmd_t cmd,
	input logic [timetag_pkg::n_targets-1:0] cmd_ack
);

	typedef enum logic [1:0] {
		st_header,
		st_data,
		st_pending
	} state_t;

	state_t state_q;
	logic [2:0] code_q;
	logic [timetag_pkg::n_targets-1:0] sel_q;
	logic [7:0] data_q;
	logic accept;

	// No new bytes while a command waits for its target
	assign cmd_ready = (state_q != st_pending);
	assign accept = cmd_wr && cmd_ready;

	assign cmd = '{sel: sel_q, data: data_q};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= st_header;
			code_q <= '0;
			sel_q <= '0;
		end
		else
		begin
			case (state_q)
				st_header:
				begin
					if (accept)
					begin
						code_q <= cmd_in[2:0];
						state_q <= st_data;
					end
				end
				st_data:
				begin
					if (accept)
					begin
						// Codes 6 and 7 name no target, drop the command here
						if (int'(code_q) < timetag_pkg::n_targets)
						begin
							sel_q <= timetag_pkg::n_targets'(1) << code_q;
							state_q <= st_pending;
						end
						else
							state_q <= st_header;
					end
				end
				default:
				begin
					if (|cmd_ack)
					begin
						sel_q <= '0;
						state_q <= st_header;
					end
				end
			endcase
		end
	end

	// Data byte is payload only
	always_ff @(posedge clk)
	begin
		if (state_q == st_data && accept)
			data_q <= cmd_in;
	end

endmodule

/* hw/run_control.sv */
module run_control (
	input logic clk,
	input logic rst_n,
	input logic sel,
	input logic [7:0] data,
	output logic ack,
	output logic run,
	output logic clear
);

	// Takes every command at once
	assign ack = sel;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run <= 1'b0;
			clear <= 1'b0;
		end
		else
		begin
			clear <= sel && data[timetag_pkg::run_clear_bit];
			// Stop has priority over start
			if (sel && data[timetag_pkg::run_stop_bit])
				run <= 1'b0;
			else if (sel && data[timetag_pkg::run_start_bit])
				run <= 1'b1;
		end
	end

endmodule

/* hw/detector_timer.sv */
module detector_timer (
	input logic clk,
	input logic rst_n,
	input logic [timetag_pkg::n_detectors-1:0] detectors,
	input logic run,
	input logic clear,
	input logic fifo_full,
	output timetag_pkg::sample_t sample,
	output logic sample_valid
);

	logic [timetag_pkg::n_detectors-1:0] sync1_q;
	logic [timetag_pkg::n_detectors-1:0] sync2_q;
	logic [timetag_pkg::n_detectors-1:0] prev_q;
	logic [timetag_pkg::n_detectors-1:0] edge_q;
	logic [timetag_pkg::n_detectors-1:0] mask_q;
	logic [timetag_pkg::time_width-1:0] count_q;
	logic [timetag_pkg::time_width-1:0] stamp_q;
	logic valid_q;
	logic lost_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q <= '0;
			edge_q <= '0;
			count_q <= '0;
			valid_q <= 1'b0;
			lost_q <= 1'b0;
		end
		else
		begin
			// Two flops against metastability
			sync1_q <= detectors;
			sync2_q <= sync1_q;
			prev_q <= sync2_q;

			// Rising edges only
			edge_q <= sync2_q & ~prev_q;

			// Edges seen while stopped are thrown away
			valid_q <= run && (|edge_q);

			if (clear)
				count_q <= '0;
			else if (run)
				count_q <= count_q + 1'b1;

			// Remember a drop until a sample makes it into the FIFO
			if (valid_q && fifo_full)
				lost_q <= 1'b1;
			else if (valid_q)
				lost_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (run && (|edge_q))
		begin
			mask_q <= edge_q;
			stamp_q <= count_q;
		end
	end

	assign sample_valid = valid_q;
	assign sample = '{lost: lost_q, mask: mask_q, timestamp: stamp_q};

endmodule

/* hw/pulse_sequencer.sv */
module pulse_sequencer (
	input logic clk,
	input logic rst_n,
	input logic sel,
	input logic [7:0] data,
	output logic ack,
	input logic run,
	output logic laser_en
);

	logic [7:0] half_q;
	logic [7:0] cnt_q;

	// Half-period is written straight away
	assign ack = sel;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			half_q <= '0;
		else if (sel)
			half_q <= data;
	end

	// cnt_q of zero means idle, otherwise cycles spent in the current phase
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt_q <= '0;
			laser_en <= 1'b0;
		end
		else if (!run || half_q == 8'd0)
		begin
			cnt_q <= '0;
			laser_en <= 1'b0;
		end
		else if (cnt_q == 8'd0)
		begin
			// First cycle of a run starts high
			cnt_q <= 8'd1;
			laser_en <= 1'b1;
		end
		else if (cnt_q >= half_q)
		begin
			cnt_q <= 8'd1;
			laser_en <= ~laser_en;
		end
		else
			cnt_q <= cnt_q + 8'd1;
	end

endmodule

/* hw/sample_fifo.sv */
module sample_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input payload_t push_data,
	output logic full,
	input logic pop,
	output payload_t head,
	output logic not_empty
);

	localparam int ptr_width = $clog2(timetag_pkg::fifo_depth);

	payload_t mem [timetag_pkg::fifo_depth];
	logic [ptr_width-1:0] wr_ptr_q;
	logic [ptr_width-1:0] rd_ptr_q;
	logic [ptr_width:0] count_q;
	logic do_push;
	logic do_pop;

	assign full = (count_q == (ptr_width+1)'(timetag_pkg::fifo_depth));
	assign not_empty = (count_q != '0);

	// Pushes into a full FIFO are ignored
	assign do_push = push && !full;
	assign do_pop = pop && not_empty;

	assign head = mem[rd_ptr_q];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_push && !do_pop)
				count_q <= count_q + 1'b1;
			else if (do_pop && !do_push)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr_q] <= push_data;
	end

endmodule

/* hw/sample_serializer.sv */
module sample_serializer (
	input logic clk,
	input logic rst_n,
	input logic not_empty,
	input timetag_pkg::sample_t head,
	output logic pop,
	output logic data_rdy,
	output logic [7:0] data,
	input logic data_ack
);

	localparam int sample_width = 8 * timetag_pkg::sample_bytes;

	logic [2:0] idx_q;
	logic [sample_width-1:0] head_bits;
	logic last_byte;

	assign head_bits = sample_width'(head);

	// Head is stale during the pop cycle, so hold off there
	assign data_rdy = not_empty && !pop;
	assign last_byte = (int'(idx_q) == timetag_pkg::sample_bytes - 1);

	// Byte 0 is the most significant
	assign data = 8'(head_bits >> (8 * (timetag_pkg::sample_bytes - 1 - int'(idx_q))));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			idx_q <= '0;
			pop <= 1'b0;
		end
		else
		begin
			pop <= data_rdy && data_ack && last_byte;
			if (data_rdy && data_ack)
			begin
				if (last_byte)
					idx_q <= '0;
				else
					idx_q <= idx_q + 3'd1;
			end
		end
	end

endmodule

/* hw/timetag_top.sv */
module timetag_top (
	input logic clk,
	input logic rst_n,
	input logic cmd_wr,
	input logic [7:0] cmd_in,
	output logic cmd_ready,
	input logic [timetag_pkg::n_detectors-1:0] detectors,
	output logic [timetag_pkg::n_detectors-1:0] laser_en,
	output logic data_rdy,
	output logic [7:0] data,
	input logic data_ack
);

	timetag_pkg::cmd_t cmd;
	logic [timetag_pkg::n_targets-1:0] cmd_ack;
	logic timer_run;
	logic timer_clear;
	logic seq_run;
	timetag_pkg::sample_t sample;
	logic sample_valid;
	logic fifo_full;
	logic fifo_not_empty;
	timetag_pkg::sample_t fifo_head;
	logic fifo_pop;

	cmd_parser i_cmd_parser (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_wr(cmd_wr),
		.cmd_in(cmd_in),
		.cmd_ready(cmd_ready),
		.cmd(cmd),
		.cmd_ack(cmd_ack)
	);

	run_control i_timer_run (
		.clk(clk),
		.rst_n(rst_n),
		.sel(cmd.sel[timetag_pkg::tgt_timer]),
		.data(cmd.data),
		.ack(cmd_ack[timetag_pkg::tgt_timer]),
		.run(timer_run),
		.clear(timer_clear)
	);

	// Sequencers have no counter to clear
	run_control i_seq_run (
		.clk(clk),
		.rst_n(rst_n),
		.sel(cmd.sel[timetag_pkg::tgt_seq_run]),
		.data(cmd.data),
		.ack(cmd_ack[timetag_pkg::tgt_seq_run]),
		.run(seq_run),
		.clear()
	);

	detector_timer i_timer (
		.clk(clk),
		.rst_n(rst_n),
		.detectors(detectors),
		.run(timer_run),
		.clear(timer_clear),
		.fifo_full(fifo_full),
		.sample(sample),
		.sample_valid(sample_valid)
	);

	for (genvar i = 0; i < timetag_pkg::n_detectors; i++)
	begin : g_seq
		pulse_sequencer i_seq (
			.clk(clk),
			.rst_n(rst_n),
			.sel(cmd.sel[timetag_pkg::tgt_seq0 + i]),
			.data(cmd.data),
			.ack(cmd_ack[timetag_pkg::tgt_seq0 + i]),
			.run(seq_run),
			.laser_en(laser_en[i])
		);
	end

	sample_fifo #(
		.payload_t(timetag_pkg::sample_t)
	) i_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(sample_valid),
		.push_data(sample),
		.full(fifo_full),
		.pop(fifo_pop),
		.head(fifo_head),
		.not_empty(fifo_not_empty)
	);

	sample_serializer i_serializer (
		.clk(clk),
		.rst_n(rst_n),
		.not_empty(fifo_not_empty),
		.head(fifo_head),
		.pop(fifo_pop),
		.data_rdy(data_rdy),
		.data(data),
		.data_ack(data_ack)
	);

endmodule

/* test/timetag_tb.sv */
module timetag_tb;

	// One expected sample, tagged with the cycle its edge was driven
	typedef struct packed {
		logic lost;
		logic [timetag_pkg::n_detectors-1:0] mask;
		logic first;
		logic [31:0] cycle;
		logic [31:0] bound;
	} edge_t;

	logic clk;
	logic rst_n;
	logic cmd_wr;
	logic [7:0] cmd_in;
	logic cmd_ready;
	logic [timetag_pkg::n_detectors-1:0] detectors;
	logic [timetag_pkg::n_detectors-1:0] laser_en;
	logic data_rdy;
	logic [7:0] data;
	logic data_ack;

	int seed;
	int cyc;
	int nbytes;
	int n_checked;
	int exp_total;
	int clear_cycle;
	logic [8*timetag_pkg::sample_bytes-1:0] acc;
	logic [31:0] base_cycle;
	logic [timetag_pkg::time_width-1:0] base_ts;
	edge_t exp_q[$];
	timetag_pkg::sample_t got_q[$];
	edge_t cur_exp;
	timetag_pkg::sample_t cur_got;

	timetag_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_wr(cmd_wr),
		.cmd_in(cmd_in),
		.cmd_ready(cmd_ready),
		.detectors(detectors),
		.laser_en(laser_en),
		.data_rdy(data_rdy),
		.data(data),
		.data_ack(data_ack)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic report_error(string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_sample(string name, timetag_pkg::sample_t got,
		timetag_pkg::sample_t exp);
		if (got !== exp)
		begin
			$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_laser(string name, logic [timetag_pkg::n_detectors-1:0] got,
		logic [timetag_pkg::n_detectors-1:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp)
		begin
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	// Expected sample from the edge cycle, relative to the first sample of its run
	function automatic timetag_pkg::sample_t expect_sample(edge_t e, logic [31:0] bc,
		logic [timetag_pkg::time_width-1:0] bts);
		timetag_pkg::sample_t s;
		s.lost = e.lost;
		s.mask = e.mask;
		s.timestamp = bts + timetag_pkg::time_width'(e.cycle - bc);
		return s;
	endfunction

	// Host side of the data port, six bytes make one sample
	always @(posedge clk)
	begin
		if (rst_n && data_rdy && data_ack)
		begin
			acc = {acc[8*timetag_pkg::sample_bytes-9:0], data};
			nbytes++;
			if (nbytes == timetag_pkg::sample_bytes)
			begin
				got_q.push_back(timetag_pkg::sample_t'(acc));
				nbytes = 0;
			end
		end
	end

	always @(negedge clk)
	begin
		if (got_q.size() != 0)
		begin
			if (exp_q.size() == 0)
				report_error("a sample arrived that no driven edge should produce");
			cur_got = got_q.pop_front();
			cur_exp = exp_q.pop_front();
			if (cur_exp.first)
			begin
				base_cycle = cur_exp.cycle;
				base_ts = cur_got.timestamp;
				if (cur_exp.bound != 0 && cur_got.timestamp >= 43'(cur_exp.bound))
					report_error("timestamp after clear is not below the elapsed cycles");
			end
			check_sample("sample", cur_got, expect_sample(cur_exp, base_cycle, base_ts));
			n_checked++;
		end
	end

	task automatic write_byte(logic [7:0] b);
		int t;
		t = 0;
		@(posedge clk);
		while (!cmd_ready)
		begin
			@(posedge clk);
			t++;
			if (t > 100)
				report_error("cmd_ready stayed low");
		end
		cmd_wr <= 1'b1;
		cmd_in <= b;
		@(posedge clk);
		cmd_wr <= 1'b0;
	endtask

	task automatic send_cmd(int code, logic [7:0] payload);
		write_byte(8'(code));
		write_byte(payload);
	endtask

	// One-cycle pulse on the detectors, then a random quiet gap
	task automatic drive_edge(logic [timetag_pkg::n_detectors-1:0] mask, bit expected,
		bit lost, bit first, bit after_clear);
		edge_t e;
		int gap;
		@(posedge clk);
		detectors <= mask;
		e.lost = lost;
		e.mask = mask;
		e.first = first;
		e.cycle = cyc;
		e.bound = after_clear ? 32'(cyc - clear_cycle + 4) : 32'd0;
		if (expected)
		begin
			exp_q.push_back(e);
			exp_total++;
		end
		@(posedge clk);
		detectors <= '0;
		gap = 1 + ($unsigned($random(seed)) % 16);
		repeat (gap) @(posedge clk);
	endtask

	function automatic logic [timetag_pkg::n_detectors-1:0] random_mask();
		logic [timetag_pkg::n_detectors-1:0] m;
		m = timetag_pkg::n_detectors'($random(seed));
		if (m == '0)
			m = 1;
		return m;
	endfunction

	task automatic wait_checked(int n);
		int t;
		t = 0;
		while (n_checked < n)
		begin
			@(posedge clk);
			t++;
			if (t > 5000)
				report_error("timed out waiting for samples on the host port");
		end
	endtask

	task automatic check_sequencers();
		logic [7:0] half [timetag_pkg::n_detectors];
		logic [timetag_pkg::n_detectors-1:0] prev;
		int len [timetag_pkg::n_detectors];
		int runs [timetag_pkg::n_detectors];
		bit rose [timetag_pkg::n_detectors];
		for (int ch = 0; ch < timetag_pkg::n_detectors; ch++)
		begin
			half[ch] = 8'(1 + ($unsigned($random(seed)) % 10));
			len[ch] = 0;
			runs[ch] = 0;
			rose[ch] = 0;
			send_cmd(timetag_pkg::tgt_seq0 + ch, half[ch]);
		end
		// Start bit set and a half-period no channel uses
		send_cmd(6, 8'h41);
		send_cmd(7, 8'h41);
		repeat (6) @(posedge clk);
		check_laser("laser_en", laser_en, '0);
		prev = laser_en;
		send_cmd(timetag_pkg::tgt_seq_run, 8'h01);
		repeat (300)
		begin
			@(posedge clk);
			for (int ch = 0; ch < timetag_pkg::n_detectors; ch++)
			begin
				len[ch]++;
				if (laser_en[ch] != prev[ch])
				begin
					// The low phase before the first rise is not a full run
					if (rose[ch])
					begin
						check_count($sformatf("laser_en[%0d] run length", ch), len[ch],
							int'(half[ch]));
						runs[ch]++;
					end
					if (laser_en[ch])
						rose[ch] = 1;
					len[ch] = 0;
				end
			end
			prev = laser_en;
		end
		for (int ch = 0; ch < timetag_pkg::n_detectors; ch++)
			if (runs[ch] < 4)
				report_error($sformatf("laser_en[%0d] did not toggle while running", ch));
		send_cmd(timetag_pkg::tgt_seq_run, 8'h02);
		repeat (4) @(posedge clk);
		check_laser("laser_en", laser_en, '0);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		cmd_wr = 1'b0;
		cmd_in = '0;
		detectors = '0;
		data_ack = 1'b1;
		seed = 32'h2afa;
		cyc = 0;
		nbytes = 0;
		n_checked = 0;
		exp_total = 0;
		clear_cycle = 0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		@(posedge clk);

		check_count("cmd_ready", int'(cmd_ready), 1);
		check_count("data_rdy", int'(data_rdy), 0);
		check_laser("laser_en", laser_en, '0);

		// Timestamps against random edges
		send_cmd(timetag_pkg::tgt_timer, 8'h01);
		repeat (4) @(posedge clk);
		drive_edge(random_mask(), 1, 0, 1, 0);
		repeat (20)
			drive_edge(random_mask(), 1, 0, 0, 0);
		wait_checked(exp_total);

		// Overflow with the host stalled
		data_ack <= 1'b0;
		repeat (timetag_pkg::fifo_depth)
			drive_edge(random_mask(), 1, 0, 0, 0);
		repeat (10) @(posedge clk);
		repeat (3)
			drive_edge(random_mask(), 0, 0, 0, 0);
		repeat (10) @(posedge clk);
		data_ack <= 1'b1;
		wait_checked(exp_total);
		drive_edge(random_mask(), 1, 1, 0, 0);
		drive_edge(random_mask(), 1, 0, 0, 0);
		wait_checked(exp_total);

		// Codes 6 and 7 must reach no target
		send_cmd(6, 8'h06);
		send_cmd(7, 8'h05);
		repeat (6) @(posedge clk);
		drive_edge(random_mask(), 1, 0, 0, 0);
		wait_checked(exp_total);

		// Clear, then stop with both start and stop set
		send_cmd(timetag_pkg::tgt_timer, 8'h04);
		clear_cycle = cyc;
		repeat (5) @(posedge clk);
		drive_edge(random_mask(), 1, 0, 1, 1);
		drive_edge(random_mask(), 1, 0, 0, 0);
		wait_checked(exp_total);
		send_cmd(timetag_pkg::tgt_timer, 8'h03);
		repeat (4) @(posedge clk);
		repeat (3)
			drive_edge(random_mask(), 0, 0, 0, 0);
		repeat (40) @(posedge clk);

		check_sequencers();

		$display("TEST PASS");
		$finish;
	end

endmodule

/* all.f */
hw/timetag_pkg.sv
hw/cmd_parser.sv
hw/run_control.sv
hw/detector_timer.sv
hw/pulse_sequencer.sv
hw/sample_fifo.sv
hw/sample_serializer.sv
hw/timetag_top.sv
test/timetag_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= timetag_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TEST PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
